// ==== mem_bus_settings.svh ====
// Sizes and base bytes for the memory bus; RAM size must be a power of two bytes, at least 8
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

// --------------------------------------------------
// Block RAM
// --------------------------------------------------
// Size in bytes, word count is a quarter of this
`define BLOCK_RAM_BYTES 4096

// --------------------------------------------------
// Peripheral base bytes (address bits 31..24)
// --------------------------------------------------
`define RAM_BASE   8'h00
// Timer register block
`define TIMER_BASE 8'h10

`endif

// ==== mem_bus_pkg.sv ====
// Bus types for the look-ahead slave side; field order inside the structs is the wire order
`default_nettype none

package mem_bus_pkg;

    // --------------------------------------------------
    // Plain widths
    // --------------------------------------------------
    // Data word
    typedef logic [31:0] word_t;
    // Byte address
    typedef logic [31:0] addr_t;
    // Byte-lane write enables
    typedef logic [3:0]  wstrb_t;
    // Peripheral select byte, addr[31:24]
    typedef logic [7:0]  base_t;

    // --------------------------------------------------
    // Bus structs
    // --------------------------------------------------
    // Look-ahead request, 70 bits
    typedef struct packed {
        logic   read;
        logic   write;
        addr_t  addr;
        word_t  wdata;
        wstrb_t wstrb;
    } la_req_t;

    // Return path, 33 bits, all zero when idle
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_ret_t;

    // Timer control bits from the register block
    typedef struct packed {
        logic enable;
        logic irq_en;
    } timer_ctrl_t;

endpackage

`default_nettype wire

// ==== la_ram.sv ====
// Block RAM powering up as zero and never cleared; word index from addr[23:2] aliases above RAM size
`timescale 1ns/1ps
`default_nettype none
`include "mem_bus_settings.svh"

module la_ram (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   sel,
    input  mem_bus_pkg::la_req_t  req,
    output mem_bus_pkg::mem_ret_t ret
);
    import mem_bus_pkg::*;

    // --------------------------------------------------
    // Array geometry
    // --------------------------------------------------
    localparam int RAM_WORDS = `BLOCK_RAM_BYTES / 4;
    localparam int IDX_W     = $clog2(RAM_WORDS);

    word_t             mem [0:RAM_WORDS-1];
    logic [IDX_W-1:0]  idx;
    logic              ready_q;
    // Set when the answered access was a read
    logic              rd_q;
    word_t             rdata_q;

    // Low word-index bits only, upper bits alias
    assign idx = req.addr[IDX_W+1:2];

    // Zero contents at power-up
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------------------------------------
    // Write lanes and read port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (sel && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        // Old word when read and write share a cycle
        if (sel && req.read) begin
            rdata_q <= mem[idx];
        end
    end

    // One-cycle ready pulse per strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            ready_q <= sel && (req.read || req.write);
            rd_q    <= sel && req.read;
        end
    end

    // Write-only answers carry zero data
    assign ret = '{ready: ready_q, rdata: rd_q ? rdata_q : '0};

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
// Decodes addr[31:24] only; targets must hold their returns at zero while not answering
`timescale 1ns/1ps
`default_nettype none
`include "mem_bus_settings.svh"

module bus_decoder (
    input  wire                   clk,
    input  wire                   reset,
    input  mem_bus_pkg::la_req_t  req,
    output logic                  ram_sel,
    output logic                  tmr_sel,
    input  mem_bus_pkg::mem_ret_t ram_ret,
    input  mem_bus_pkg::mem_ret_t tmr_ret,
    output mem_bus_pkg::mem_ret_t ret
);
    import mem_bus_pkg::*;

    base_t    base;
    logic     strobe;
    logic     unmapped_q;
    mem_ret_t unmapped_ret;

    // --------------------------------------------------
    // Target select
    // --------------------------------------------------
    // Peripheral byte of the address
    assign base = req.addr[31:24];

    assign ram_sel = (base == `RAM_BASE);
    assign tmr_sel = (base == `TIMER_BASE);

    assign strobe = req.read || req.write;

    // --------------------------------------------------
    // Unmapped answer
    // --------------------------------------------------
    // Keeps the core from hanging on a stray address
    always_ff @(posedge clk) begin
        if (reset) begin
            unmapped_q <= 1'b0;
        end else begin
            unmapped_q <= strobe && !ram_sel && !tmr_sel;
        end
    end

    // Ready only, data stays zero
    assign unmapped_ret = '{ready: unmapped_q, rdata: '0};

    // --------------------------------------------------
    // Return merge
    // --------------------------------------------------
    // Idle targets return zero so a plain OR is enough
    assign ret = ram_ret | tmr_ret | unmapped_ret;

endmodule

`default_nettype wire

// ==== timer_regs.sv ====
// Timer registers at word offsets 0..3 from addr[3:2], higher bits alias; byte strobes ignored
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      sel,
    input  mem_bus_pkg::la_req_t     req,
    output mem_bus_pkg::mem_ret_t    ret,
    output mem_bus_pkg::timer_ctrl_t ctrl,
    output mem_bus_pkg::word_t       compare,
    output logic                     load,
    output mem_bus_pkg::word_t       load_value,
    output logic                     clear_match,
    input  mem_bus_pkg::word_t       count,
    input  wire                      match
);
    import mem_bus_pkg::*;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam logic [1:0] OFS_CTRL    = 2'd0;
    localparam logic [1:0] OFS_COMPARE = 2'd1;
    localparam logic [1:0] OFS_COUNT   = 2'd2;
    localparam logic [1:0] OFS_STATUS  = 2'd3;

    logic [1:0] ofs;
    logic       wr;
    logic       ready_q;
    logic       rd_q;
    word_t      rdata_q;
    word_t      rd_mux;

    assign ofs = req.addr[3:2];
    // Whole-word write to this block
    assign wr  = sel && req.write;

    // Control and compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl    <= '0;
            compare <= '0;
        end else begin
            if (wr && ofs == OFS_CTRL) begin
                ctrl <= '{enable: req.wdata[0], irq_en: req.wdata[1]};
            end
            if (wr && ofs == OFS_COMPARE) begin
                compare <= req.wdata;
            end
        end
    end

    // Counter acts on these at the sampling edge
    assign load        = wr && (ofs == OFS_COUNT);
    assign load_value  = req.wdata;
    assign clear_match = wr && (ofs == OFS_STATUS) && req.wdata[0];

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_comb begin
        case (ofs)
            OFS_CTRL:    rd_mux = {30'd0, ctrl.irq_en, ctrl.enable};
            OFS_COMPARE: rd_mux = compare;
            OFS_COUNT:   rd_mux = count;
            default:     rd_mux = {31'd0, match};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            ready_q <= sel && (req.read || req.write);
            rd_q    <= sel && req.read;
        end
        rdata_q <= rd_mux;
    end

    assign ret = '{ready: ready_q, rdata: rd_q ? rdata_q : '0};

endmodule

`default_nettype wire

// ==== timer_core.sv ====
// Counter wraps to zero after reaching compare; match is sticky, set beats clear in one cycle
`timescale 1ns/1ps
`default_nettype none

module timer_core (
    input  wire                      clk,
    input  wire                      reset,
    input  mem_bus_pkg::timer_ctrl_t ctrl,
    input  mem_bus_pkg::word_t       compare,
    input  wire                      load,
    input  mem_bus_pkg::word_t       load_value,
    input  wire                      clear_match,
    output mem_bus_pkg::word_t       count,
    output logic                     match,
    output logic                     timer_irq
);
    import mem_bus_pkg::*;

    word_t count_next;
    logic  hit;

    // Compare hit only while running and not being loaded
    assign hit = ctrl.enable && !load && (count == compare);

    // --------------------------------------------------
    // Next count
    // --------------------------------------------------
    always_comb begin
        count_next = count;
        if (load) begin
            count_next = load_value;
        end else if (ctrl.enable) begin
            count_next = (count == compare) ? '0 : count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            match     <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            count <= count_next;
            if (hit) begin
                match <= 1'b1;
            end else if (clear_match) begin
                match <= 1'b0;
            end
            // One cycle behind match
            timer_irq <= match && ctrl.irq_en;
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsystem.sv ====
// Slave side of the look-ahead bus; every strobe is answered one cycle later, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire                   clk,
    input  wire                   reset,
    input  mem_bus_pkg::la_req_t  req,
    output mem_bus_pkg::mem_ret_t ret,
    output logic                  timer_irq
);
    import mem_bus_pkg::*;

    // --------------------------------------------------
    // Decoder to targets
    // --------------------------------------------------
    logic     ram_sel;
    logic     tmr_sel;
    mem_ret_t ram_ret;
    mem_ret_t tmr_ret;

    // Register block to counter
    timer_ctrl_t ctrl;
    word_t       compare;
    word_t       load_value;
    word_t       count;
    logic        load;
    logic        clear_match;
    logic        match;

    bus_decoder u_decoder (
        .clk(clk), .reset(reset), .req(req),
        .ram_sel(ram_sel), .tmr_sel(tmr_sel),
        .ram_ret(ram_ret), .tmr_ret(tmr_ret), .ret(ret)
    );

    la_ram u_ram (
        .clk(clk), .reset(reset), .sel(ram_sel), .req(req), .ret(ram_ret)
    );

    // Timer pair
    timer_regs u_timer_regs (
        .clk(clk), .reset(reset), .sel(tmr_sel), .req(req), .ret(tmr_ret),
        .ctrl(ctrl), .compare(compare), .load(load), .load_value(load_value),
        .clear_match(clear_match), .count(count), .match(match)
    );

    timer_core u_timer_core (
        .clk(clk), .reset(reset), .ctrl(ctrl), .compare(compare),
        .load(load), .load_value(load_value), .clear_match(clear_match),
        .count(count), .match(match), .timer_irq(timer_irq)
    );

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
// Directed testbench; assumes RAM and timer bases differ from 8'h20, which is used as unmapped
`timescale 1ns/1ps
`default_nettype none
`include "mem_bus_settings.svh"

module tb_mem_subsystem;
    import mem_bus_pkg::*;

    localparam int RAM_WORDS   = `BLOCK_RAM_BYTES / 4;
    localparam int IDX_W       = $clog2(RAM_WORDS);
    // Far above the summed length of all tests
    localparam int CYCLE_LIMIT = 3000;
    localparam int CMP_VALUE   = 20;

    logic     clk;
    logic     reset;
    la_req_t  req;
    mem_ret_t ret;
    logic     timer_irq;

    // Expected RAM contents
    word_t       model [0:RAM_WORDS-1];
    logic [31:0] lfsr_state;
    int          cycles = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    mem_subsystem u_dut (
        .clk(clk), .reset(reset), .req(req), .ret(ret), .timer_irq(timer_irq)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // --------------------------------------------------
    // Run limit
    // --------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic addr_t ram_addr(input logic [IDX_W-1:0] idx);
        addr_t a;
        a = '0;
        a[31:24] = `RAM_BASE;
        a[IDX_W+1:2] = idx;
        return a;
    endfunction

    function automatic addr_t tmr_addr(input logic [1:0] ofs);
        addr_t a;
        a = '0;
        a[31:24] = `TIMER_BASE;
        a[3:2] = ofs;
        return a;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic expect_ready(input string kind, input addr_t addr);
        if (ret.ready !== 1'b1) begin
            $display("No ready one cycle after the %s strobe to %h at %0t", kind, addr, $time);
            protocol_errors++;
        end
    endtask

    // Strobe for one cycle, sample the answer half a cycle after the next rising edge
    task automatic bus_write(input addr_t addr, input word_t data, input wstrb_t strb);
        @(negedge clk);
        req = '{read: 1'b0, write: 1'b1, addr: addr, wdata: data, wstrb: strb};
        @(posedge clk);
        @(negedge clk);
        expect_ready("write", addr);
        check_word("ret.rdata", '0, ret.rdata);
        req = '0;
    endtask

    task automatic bus_read(input addr_t addr, output word_t data);
        @(negedge clk);
        req = '{read: 1'b1, write: 1'b0, addr: addr, wdata: '0, wstrb: '0};
        @(posedge clk);
        @(negedge clk);
        expect_ready("read", addr);
        data = ret.rdata;
        req = '0;
    endtask

    task automatic wait_for_irq(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (timer_irq !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq !== level) begin
            $display("timer_irq did not reach %b within %0d cycles at %0t", level, max_cycles,
                     $time);
            protocol_errors++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_ram_words();
        logic [IDX_W-1:0] idx_list [16];
        word_t            d;
        word_t            got;
        for (int i = 0; i < 16; i++) begin
            idx_list[i] = IDX_W'(rand_bits(IDX_W));
            d = rand_bits(32);
            model[idx_list[i]] = d;
            bus_write(ram_addr(idx_list[i]), d, 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(ram_addr(idx_list[i]), got);
            check_word("ram rdata", model[idx_list[i]], got);
        end
    endtask

    task automatic test_ram_lanes();
        logic [IDX_W-1:0] idx;
        wstrb_t           strb;
        word_t            d;
        word_t            got;
        for (int i = 0; i < 12; i++) begin
            idx  = IDX_W'(rand_bits(IDX_W));
            strb = wstrb_t'(rand_bits(4));
            d    = rand_bits(32);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model[idx][8*b +: 8] = d[8*b +: 8];
            end
            bus_write(ram_addr(idx), d, strb);
            bus_read(ram_addr(idx), got);
            check_word("ram lane rdata", model[idx], got);
        end
        // One RAM size up lands on the same word
        idx = IDX_W'(rand_bits(IDX_W));
        d   = rand_bits(32);
        model[idx] = d;
        bus_write(ram_addr(idx) + `BLOCK_RAM_BYTES, d, 4'hf);
        bus_read(ram_addr(idx), got);
        check_word("ram alias rdata", model[idx], got);
        bus_read(ram_addr(idx) + `BLOCK_RAM_BYTES, got);
        check_word("ram alias rdata", model[idx], got);
    endtask

    task automatic test_unmapped();
        addr_t a;
        word_t got;
        a = rand_bits(32);
        a[31:24] = 8'h20;
        bus_read(a, got);
        check_word("unmapped rdata", '0, got);
        // Idle cycle after the answer
        @(negedge clk);
        check_bit("ret.ready idle", 1'b0, ret.ready);
        bus_write(a, rand_bits(32), 4'hf);
        @(negedge clk);
        check_bit("ret.ready idle", 1'b0, ret.ready);
    endtask

    task automatic test_timer_regs();
        word_t v;
        word_t got;
        // Each control bit set on its own, upper bits not stored
        v = rand_bits(32);
        v[1:0] = 2'b01;
        bus_write(tmr_addr(2'd0), v, 4'hf);
        bus_read(tmr_addr(2'd0), got);
        check_word("timer ctrl", 32'h1, got);
        v = rand_bits(32);
        v[1:0] = 2'b10;
        bus_write(tmr_addr(2'd0), v, 4'hf);
        bus_read(tmr_addr(2'd0), got);
        check_word("timer ctrl", 32'h2, got);
        // Counter stopped before the count test
        bus_write(tmr_addr(2'd0), '0, 4'hf);
        // Single lane strobe still writes the whole word
        v = rand_bits(32);
        bus_write(tmr_addr(2'd1), v, 4'h1);
        bus_read(tmr_addr(2'd1), got);
        check_word("timer compare", v, got);
        v = rand_bits(32);
        bus_write(tmr_addr(2'd2), v, 4'hf);
        bus_read(tmr_addr(2'd2), got);
        check_word("timer count", v, got);
    endtask

    task automatic test_timer_match();
        word_t got;
        int    start;
        logic  seen;
        bus_write(tmr_addr(2'd1), word_t'(CMP_VALUE), 4'hf);
        bus_write(tmr_addr(2'd2), '0, 4'hf);
        bus_write(tmr_addr(2'd3), 32'h1, 4'hf);
        // Run, no interrupt
        bus_write(tmr_addr(2'd0), 32'h1, 4'hf);
        start = cycles;
        seen  = 1'b0;
        while (!seen && (cycles - start) <= CMP_VALUE + 4) begin
            bus_read(tmr_addr(2'd3), got);
            check_bit("timer_irq", 1'b0, timer_irq);
            seen = got[0];
        end
        if (!seen) begin
            $display("Match not set within %0d cycles of enabling the timer", CMP_VALUE + 4);
            protocol_errors++;
        end
        bus_write(tmr_addr(2'd0), 32'h3, 4'hf);
        wait_for_irq(1'b1, 4);
        // Stop counting, interrupt held by sticky match
        bus_write(tmr_addr(2'd0), 32'h2, 4'hf);
        check_bit("timer_irq", 1'b1, timer_irq);
        bus_write(tmr_addr(2'd3), 32'h1, 4'hf);
        wait_for_irq(1'b0, 4);
        bus_read(tmr_addr(2'd3), got);
        check_bit("timer match", 1'b0, got[0]);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        req        = '0;
        lfsr_state = 32'h7ce8_272f;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("ret.ready", 1'b0, ret.ready);
        check_bit("timer_irq", 1'b0, timer_irq);

        test_ram_words();
        test_ram_lanes();
        test_unmapped();
        test_timer_regs();
        test_timer_match();

        $display("Errors: %0d value mismatches, %0d handshake or timing failures",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mem_bus_pkg.sv
la_ram.sv
bus_decoder.sv
timer_regs.sv
timer_core.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail taken from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_mem_subsystem -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
